//--- include/exti_cfg.svh
// ######################################
// sizes and bus map of the interrupt subsystem
// each window is three words, addresses must not overlap
// changing EXTI_NSRC also needs new event wiring in exti_regs
// ######################################
`ifndef EXTI_CFG_SVH
`define EXTI_CFG_SVH

// system bus widths
`define EXTI_WORDSIZE 16
`define EXTI_ADDRSIZE 16

// controller registers are one byte wide, upper bits read zero
`define EXTI_REGSIZE 8

// controller window, enable / level / status
`define EXTI_BASE   16'hFF0C
`define EXTI_NWORDS 3

// timer window, reload / ctrl / count
`define TIMER_BASE   16'hFF10
`define TIMER_NWORDS 3

// interrupt sources and cpu lines
`define EXTI_NSRC   3
`define EXTI_NLINES 4

`endif

//--- logic/exti_pkg.sv
// ######################################
// shared types of the interrupt subsystem
// widths come from exti_cfg.svh
// ######################################
`include "exti_cfg.svh"

package exti_pkg;

    // one bus beat, no handshake, read data comes back combinationally
    typedef struct packed {
        logic                       enable;
        logic [`EXTI_ADDRSIZE-1:0]  addr;
        logic                       write_en;
        logic [`EXTI_WORDSIZE-1:0]  wdata;
    } bus_req_t;

    // word offsets inside the controller window
    typedef enum logic [1:0] {
        reg_enable = 2'd0,
        reg_level  = 2'd1,
        reg_status = 2'd2
    } exti_reg_e;

    // word offsets inside the timer window
    typedef enum logic [1:0] {
        tmr_reload = 2'd0,
        tmr_ctrl   = 2'd1,
        tmr_count  = 2'd2
    } timer_reg_e;

    // bit index of each source in enable and status
    typedef enum logic [1:0] {
        src_gpio  = 2'd0,
        src_uart  = 2'd1,
        src_timer = 2'd2
    } int_src_e;

    // routing setup of one source
    typedef struct packed {
        logic       en;
        logic [1:0] level;
    } src_cfg_t;

endpackage

//--- logic/exti_regs.sv
// ######################################
// controller registers at EXTI_BASE
// registers are 8 bit, bits 15:8 read as zero
// events are single-cycle pulses and always beat a status clear
// read data is zero outside the window
// ######################################
`timescale 1ns/1ps
`include "exti_cfg.svh"

module exti_regs import exti_pkg::*; (
    input  logic                          clk,
    input  logic                          rst_n,
    input  bus_req_t                      bus,
    input  logic                          uart_evt,
    input  logic                          gpio_evt,
    input  logic                          timer_evt,
    output logic [`EXTI_WORDSIZE-1:0]     data_out,
    output src_cfg_t [`EXTI_NSRC-1:0]     cfg,
    output logic [`EXTI_NSRC-1:0]         pending
);

    localparam int reg_w = `EXTI_REGSIZE;
    localparam logic [`EXTI_ADDRSIZE-1:0] base_addr = `EXTI_BASE;

    logic             hit;
    logic             wr;
    exti_reg_e        offset;
    logic [reg_w-1:0] enable_q;
    logic [reg_w-1:0] level_q;
    logic [reg_w-1:0] status_q;
    logic [reg_w-1:0] status_d;
    logic [`EXTI_NSRC-1:0] evt;

    // window decode, three words from the base
    assign hit = bus.enable && (bus.addr >= base_addr)
                 && (bus.addr < base_addr + `EXTI_NWORDS);
    assign wr  = hit && bus.write_en;

    // window is smaller than four words so two address bits are enough
    assign offset = exti_reg_e'(bus.addr[1:0] - base_addr[1:0]);

    // gather event pulses by source index
    assign evt[src_gpio]  = gpio_evt;
    assign evt[src_uart]  = uart_evt;
    assign evt[src_timer] = timer_evt;

    // status next value
    always_comb begin
        status_d = status_q;
        // software write first
        if (wr && offset == reg_status) begin
            status_d = bus.wdata[reg_w-1:0];
        end
        // events on top, so a pulse survives a clear in the same cycle
        status_d = status_d | reg_w'(evt);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            enable_q <= '0;
            level_q  <= '0;
            status_q <= '0;
        end else begin
            if (wr && offset == reg_enable) begin
                enable_q <= bus.wdata[reg_w-1:0];
            end
            if (wr && offset == reg_level) begin
                level_q <= bus.wdata[reg_w-1:0];
            end
            status_q <= status_d;
        end
    end

    // per-source routing setup for the router
    // source s uses enable bit s and level bits 2s+1:2s
    always_comb begin
        for (int s = 0; s < `EXTI_NSRC; s++) begin
            cfg[s].en    = enable_q[s];
            cfg[s].level = level_q[2*s +: 2];
        end
    end

    assign pending = status_q[`EXTI_NSRC-1:0];

    // read-back, zero when not addressed
    always_comb begin
        data_out = '0;
        if (hit) begin
            case (offset)
                reg_enable: data_out = {{(`EXTI_WORDSIZE-reg_w){1'b0}}, enable_q};
                reg_level:  data_out = {{(`EXTI_WORDSIZE-reg_w){1'b0}}, level_q};
                reg_status: data_out = {{(`EXTI_WORDSIZE-reg_w){1'b0}}, status_q};
                default:    data_out = '0;
            endcase
        end
    end

    // a pulse must show up as pending one cycle later, whatever the bus does
    for (genvar s = 0; s < `EXTI_NSRC; s++) begin : g_evt_chk
        a_evt_sets_status: assert property (
            @(posedge clk) disable iff (!rst_n)
            evt[s] |=> status_q[s]
        ) else $error("event on source %0d did not set its status bit", s);
    end

endmodule

//--- logic/exti_router.sv
// ######################################
// maps pending sources onto cpu lines
// purely combinational, no priority between sources
// sources sharing a line are ORed
// ######################################
`timescale 1ns/1ps
`include "exti_cfg.svh"

module exti_router import exti_pkg::*; (
    input  src_cfg_t [`EXTI_NSRC-1:0]     cfg,
    input  logic [`EXTI_NSRC-1:0]         pending,
    output logic [`EXTI_NLINES-1:0]       cpu_int
);

    always_comb begin
        logic [`EXTI_NLINES-1:0] sel;
        cpu_int = '0;
        for (int s = 0; s < `EXTI_NSRC; s++) begin
            // level number to one-hot line
            sel = `EXTI_NLINES'(1) << cfg[s].level;
            // only a pending and enabled source drives its line
            if (cfg[s].en && pending[s]) begin
                cpu_int = cpu_int | sel;
            end
        end
    end

    // nothing pending means every line idle, regardless of enables and levels
    always_comb begin
        if (pending == '0) begin
            a_idle_lines: assert final (cpu_int == '0)
                else $error("cpu_int %b active with no source pending", cpu_int);
        end
    end

endmodule

//--- logic/periph_timer.sv
// ######################################
// down-counting timer at TIMER_BASE
// ctrl bit 0 runs the timer, other ctrl bits read zero
// period is reload+1 cycles, count is read-only
// while stopped, count follows reload
// ######################################
`timescale 1ns/1ps
`include "exti_cfg.svh"

module periph_timer import exti_pkg::*; (
    input  logic                          clk,
    input  logic                          rst_n,
    input  bus_req_t                      bus,
    output logic [`EXTI_WORDSIZE-1:0]     data_out,
    output logic                          timer_evt
);

    localparam logic [`EXTI_ADDRSIZE-1:0] base_addr = `TIMER_BASE;

    logic                       hit;
    logic                       wr;
    timer_reg_e                 offset;
    logic [`EXTI_WORDSIZE-1:0]  reload_q;
    logic                       run_q;
    logic [`EXTI_WORDSIZE-1:0]  count_q;

    // window decode
    assign hit = bus.enable && (bus.addr >= base_addr)
                 && (bus.addr < base_addr + `TIMER_NWORDS);
    assign wr  = hit && bus.write_en;
    assign offset = timer_reg_e'(bus.addr[1:0] - base_addr[1:0]);

    // control registers, a write to tmr_count has no effect
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            reload_q <= '0;
            run_q    <= 1'b0;
        end else begin
            if (wr && offset == tmr_reload) begin
                reload_q <= bus.wdata;
            end
            if (wr && offset == tmr_ctrl) begin
                run_q <= bus.wdata[0];
            end
        end
    end

    // counter
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count_q <= '0;
        end else if (!run_q) begin
            // preload so the first period after start is full length
            count_q <= reload_q;
        end else if (count_q == '0) begin
            // wrap
            count_q <= reload_q;
        end else begin
            count_q <= count_q - 1'b1;
        end
    end

    // event for the whole cycle the running counter sits at zero
    assign timer_evt = run_q && (count_q == '0);

    // read-back
    always_comb begin
        data_out = '0;
        if (hit) begin
            case (offset)
                tmr_reload: data_out = reload_q;
                tmr_ctrl:   data_out = {{(`EXTI_WORDSIZE-1){1'b0}}, run_q};
                tmr_count:  data_out = count_q;
                default:    data_out = '0;
            endcase
        end
    end

    // with a nonzero reload the wrap always leaves zero, so no back-to-back pulses
    a_evt_single: assert property (
        @(posedge clk) disable iff (!rst_n)
        (timer_evt && reload_q != '0) |=> !timer_evt
    ) else $error("timer_evt held for two cycles with reload %0d", reload_q);

endmodule

//--- logic/gpio_edge.sv
// ######################################
// rising-edge detector for an async GPIO pin
// pulse comes 3 edges after the pin is first sampled
// pin pulses shorter than a clock may be missed
// ######################################
`timescale 1ns/1ps

module gpio_edge (
    input  logic clk,
    input  logic rst_n,
    input  logic pin,
    output logic gpio_evt
);

    logic sync1_q;
    logic sync2_q;
    logic hist_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sync1_q  <= 1'b0;
            sync2_q  <= 1'b0;
            hist_q   <= 1'b0;
            gpio_evt <= 1'b0;
        end else begin
            // two-flop synchroniser
            sync1_q <= pin;
            sync2_q <= sync1_q;
            // previous synchronised level
            hist_q  <= sync2_q;
            // registered so the pulse is glitch free toward the controller
            gpio_evt <= sync2_q && !hist_q;
        end
    end

endmodule

//--- logic/exti_subsys_top.sv
// ######################################
// interrupt subsystem top level
// bus has no handshake, reads are combinational
// uart_evt must be a one-cycle pulse in the clk domain
// gpio_pin may be asynchronous
// ######################################
`timescale 1ns/1ps
`include "exti_cfg.svh"

module exti_subsys_top import exti_pkg::*; (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          enable,
    input  logic [`EXTI_ADDRSIZE-1:0]     addr,
    input  logic                          write_en,
    input  logic [`EXTI_WORDSIZE-1:0]     data_in,
    output logic [`EXTI_WORDSIZE-1:0]     data_out,
    input  logic                          gpio_pin,
    input  logic                          uart_evt,
    output logic [`EXTI_NLINES-1:0]       cpu_int
);

    bus_req_t                   bus;
    logic [`EXTI_WORDSIZE-1:0]  exti_dout;
    logic [`EXTI_WORDSIZE-1:0]  timer_dout;
    logic                       gpio_evt;
    logic                       timer_evt;
    src_cfg_t [`EXTI_NSRC-1:0]  cfg;
    logic [`EXTI_NSRC-1:0]      pending;

    // pack the outside bus once, both slaves see the same beat
    assign bus.enable   = enable;
    assign bus.addr     = addr;
    assign bus.write_en = write_en;
    assign bus.wdata    = data_in;

    exti_regs u_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .bus       (bus),
        .uart_evt  (uart_evt),
        .gpio_evt  (gpio_evt),
        .timer_evt (timer_evt),
        .data_out  (exti_dout),
        .cfg       (cfg),
        .pending   (pending)
    );

    exti_router u_router (
        .cfg     (cfg),
        .pending (pending),
        .cpu_int (cpu_int)
    );

    periph_timer u_timer (
        .clk       (clk),
        .rst_n     (rst_n),
        .bus       (bus),
        .data_out  (timer_dout),
        .timer_evt (timer_evt)
    );

    gpio_edge u_gpio (
        .clk      (clk),
        .rst_n    (rst_n),
        .pin      (gpio_pin),
        .gpio_evt (gpio_evt)
    );

    // each slave is zero outside its window
    assign data_out = exti_dout | timer_dout;

endmodule

//--- tests/clk_gen.sv
// ########################################
// testbench clock and reset
// reset is synchronous, held low for rst_cycles edges
// rst_n releases 1 ns after an edge
// ########################################
`timescale 1ns/1ps

module clk_gen #(
    parameter int period_ns  = 8,
    parameter int rst_cycles = 2
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (rst_cycles) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

endmodule

//--- tests/exti_tb.sv
// ########################################
// testbench of the interrupt subsystem
// replays tests/exti_cases.txt and must run from the project root
// then a seeded random write sweep over the r/w registers
// expect column is data_out for read and cpu_int for the other ops
// inputs change 1 ns after the rising edge
// ########################################
`timescale 1ns/1ps
`include "exti_cfg.svh"

module exti_tb;

    localparam int max_cases = 64;
    localparam int sweep_len = 16;

    // controller registers are one byte wide on the 16-bit bus
    localparam logic [15:0] ctrl_reg_mask = 16'h00ff;

    logic                       clk;
    logic                       rst_n;
    logic                       enable;
    logic [`EXTI_ADDRSIZE-1:0]  addr;
    logic                       write_en;
    logic [`EXTI_WORDSIZE-1:0]  data_in;
    logic [`EXTI_WORDSIZE-1:0]  data_out;
    logic                       gpio_pin;
    logic                       uart_evt;
    logic [`EXTI_NLINES-1:0]    cpu_int;

    // case table filled once before the run
    logic [63:0] case_op   [max_cases];
    logic [15:0] case_addr [max_cases];
    logic [15:0] case_data [max_cases];
    int          case_cyc  [max_cases];
    logic [15:0] case_exp  [max_cases];
    int          n_cases;
    int          total_cycles;
    bit          loaded;
    bit          ok;
    int          n_checks;
    int          n_errors;
    integer      seed;

    clk_gen #(.period_ns(8), .rst_cycles(2)) u_clk (
        .clk   (clk),
        .rst_n (rst_n)
    );

    exti_subsys_top DUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .enable   (enable),
        .addr     (addr),
        .write_en (write_en),
        .data_in  (data_in),
        .data_out (data_out),
        .gpio_pin (gpio_pin),
        .uart_evt (uart_evt),
        .cpu_int  (cpu_int)
    );

    // wait for the next edge and move on to the drive point
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic bus_idle();
        enable   = 1'b0;
        write_en = 1'b0;
        addr     = '0;
        data_in  = '0;
    endtask

    task automatic bus_write(input logic [15:0] a, input logic [15:0] d);
        enable   = 1'b1;
        write_en = 1'b1;
        addr     = a;
        data_in  = d;
    endtask

    // one write beat taken at the next edge
    task automatic write_reg(input logic [15:0] a, input logic [15:0] d);
        bus_write(a, d);
        step();
        bus_idle();
    endtask

    // cpu_int only moves on edges so it is stable at the drive point
    task automatic check_lines(input logic [3:0] exp);
        n_checks++;
        assert (cpu_int === exp) else begin
            $display("[ERROR] t=%0t cpu_int expected %h got %h", $time, exp, cpu_int);
            n_errors++;
        end
    endtask

    // read data is combinational and sampled 2 ns after the address goes out
    task automatic check_read(input logic [15:0] a, input logic [15:0] exp);
        logic [15:0] got;
        enable   = 1'b1;
        write_en = 1'b0;
        addr     = a;
        #2;
        got = data_out;
        n_checks++;
        assert (got === exp) else begin
            $display("[ERROR] t=%0t data_out at %h expected %h got %h", $time, a, exp, got);
            n_errors++;
        end
        step();
        bus_idle();
    endtask

    // lines whose first token is a lone # are comments
    task automatic load_cases(output bit good);
        integer           fd;
        integer           cnt;
        integer           c;
        logic [8*160-1:0] line;
        logic [63:0]      op;
        logic [15:0]      a;
        logic [15:0]      d;
        logic [15:0]      e;
        n_cases      = 0;
        total_cycles = 0;
        fd = $fopen("tests/exti_cases.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                line = '0;
                op   = '0;
                if ($fgets(line, fd) > 0) begin
                    cnt = $sscanf(line, "%s %h %h %d %h", op, a, d, c, e);
                    if (cnt == 5 && op != "#" && n_cases < max_cases) begin
                        case_op[n_cases]   = op;
                        case_addr[n_cases] = a;
                        case_data[n_cases] = d;
                        case_cyc[n_cases]  = c;
                        case_exp[n_cases]  = e;
                        // op beat plus idle cycles plus slack
                        total_cycles += c + 2;
                        n_cases++;
                    end
                end
            end
            $fclose(fd);
        end
        good = (n_cases > 0);
    endtask

    task automatic run_case(input int i);
        int          errs_before;
        logic [63:0] op;
        errs_before = n_errors;
        op = case_op[i];
        if (op == "read") begin
            check_read(case_addr[i], case_exp[i]);
            repeat (case_cyc[i]) step();
        end else begin
            if (op == "write") begin
                write_reg(case_addr[i], case_data[i]);
            end else if (op == "uart") begin
                uart_evt = 1'b1;
                // a nonzero address puts a bus write in the same cycle as the pulse
                if (case_addr[i] != '0) begin
                    bus_write(case_addr[i], case_data[i]);
                end
                step();
                uart_evt = 1'b0;
                bus_idle();
            end else if (op == "gpio") begin
                // pin level stays until the next gpio case
                gpio_pin = case_data[i][0];
            end else if (op != "idle") begin
                $display("case %0d has an operation the testbench does not know", i + 1);
                n_errors++;
            end
            repeat (case_cyc[i]) step();
            check_lines(case_exp[i][3:0]);
        end
        $display("case %0d %0s %h: %s", i + 1, op, case_addr[i],
                 (n_errors == errs_before) ? "ok" : "failed");
    endtask

    // controller registers keep the low byte and the timer reload keeps all 16 bits
    task automatic random_sweep();
        int          errs_before;
        logic [15:0] v;
        errs_before = n_errors;
        for (int k = 0; k < sweep_len; k++) begin
            v = $random(seed);
            write_reg(`EXTI_BASE, v);
            check_read(`EXTI_BASE, v & ctrl_reg_mask);
            v = $random(seed);
            write_reg(`EXTI_BASE + 1, v);
            check_read(`EXTI_BASE + 1, v & ctrl_reg_mask);
            v = $random(seed);
            write_reg(`TIMER_BASE, v);
            check_read(`TIMER_BASE, v);
        end
        $display("random sweep of %0d rounds: %s", sweep_len,
                 (n_errors == errs_before) ? "ok" : "failed");
    endtask

    // run limit follows the case file length and the sweep takes 6 cycles a round
    initial begin : watchdog
        wait (loaded);
        #((total_cycles + 8 * sweep_len + 50) * 8);
        $display("timeout, the run did not finish in the time the cases allow");
        $display(">>> FAIL");
        $finish;
    end

    initial begin : main
        seed     = 32'h1230_d2bc;
        n_checks = 0;
        n_errors = 0;
        loaded   = 1'b0;
        gpio_pin = 1'b0;
        uart_evt = 1'b0;
        bus_idle();
        load_cases(ok);
        if (!ok) begin
            $display("case file tests/exti_cases.txt is missing or holds no cases");
            $display(">>> FAIL");
            $finish;
        end else begin
            loaded = 1'b1;
            wait (rst_n);
            step();
            for (int i = 0; i < n_cases; i++) begin
                run_case(i);
            end
            random_sweep();
            $display("%0d cases, %0d checks, %0d errors", n_cases, n_checks, n_errors);
            if (n_errors == 0) begin
                $display(">>> PASS");
            end else begin
                $display(">>> FAIL");
            end
            $finish;
        end
    end

endmodule

//--- tests/exti_cases.txt
# op addr data cycles expect (hex, hex, hex, decimal, hex)
# expect is data_out for read and cpu_int after the op for all others
read  ff0c 0000 0 0000
write ff0c 00a5 0 0
read  ff0c 0000 0 00a5
write ff0d 1234 0 0
read  ff0d 0000 0 0034
write ff10 beef 0 0
read  ff10 0000 0 beef
read  ff12 0000 0 beef
read  ff0f 0000 0 0000
read  0000 0000 0 0000
read  ff0e 0000 0 0000
write ff0c 0002 0 0
write ff0d 0008 0 0
uart  0000 0000 0 4
read  ff0e 0000 0 0002
write ff0e 0000 0 0
gpio  0000 0001 4 0
read  ff0e 0000 0 0001
write ff0c 0003 0 1
gpio  0000 0000 1 1
write ff0e 0000 0 0
write ff0d 0037 0 0
write ff0c 0007 0 0
gpio  0000 0001 4 8
uart  0000 0000 0 a
write ff0e 0000 0 0
gpio  0000 0000 0 0
write ff10 0005 0 0
write ff11 0001 5 0
idle  0000 0000 1 8
read  ff12 0000 0 0005
read  ff12 0000 0 0004
write ff0e 0000 0 0
idle  0000 0000 2 0
idle  0000 0000 1 8
read  ff12 0000 0 0005
write ff11 0000 0 8
write ff0e 0000 0 0
idle  0000 0000 8 0
gpio  0000 0001 4 8
uart  ff0e 0000 0 2
read  ff0e 0000 0 0002
gpio  0000 0000 0 2
write ff0e 0000 0 0

//--- build.f
+incdir+include
logic/exti_pkg.sv
logic/exti_regs.sv
logic/exti_router.sv
logic/periph_timer.sv
logic/gpio_edge.sv
logic/exti_subsys_top.sv
tests/clk_gen.sv
tests/exti_tb.sv

//--- Bender.yml
package:
  name: exti_subsys

export_include_dirs:
  - include

sources:
  - files:
      - logic/exti_pkg.sv
      - logic/exti_regs.sv
      - logic/exti_router.sv
      - logic/periph_timer.sv
      - logic/gpio_edge.sv
      - logic/exti_subsys_top.sv
  - target: test
    files:
      - tests/clk_gen.sv
      - tests/exti_tb.sv
